// File: filelist.f
+incdir+.
sctrl_pkg.sv
sctrl_axi_slave.sv
sctrl_buffer.sv
sctrl_top.sv
tb_clkgen.sv
tb_sctrl_sva.sv
tb_sctrl.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sctrl -f filelist.f \
    && ./obj_dir/Vtb_sctrl +verilator+error+limit+1000 \
    | tee /dev/stderr \
    | grep -x "Testbench passed" > /dev/null \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation not ok"; exit 1; }

// File: tb_sctrl.sv
`timescale 1ns/1ps
`include "sctrl_params.svh"

module tb_sctrl;
    import sctrl_pkg::*;

    localparam int HS_TIMEOUT   = 50;
    localparam int FILL_TIMEOUT = 2000;
    localparam int OP_WR_JOINT  = 0;
    localparam int OP_WR_SPLIT  = 1;
    localparam int OP_RD        = 2;
    localparam int OP_FILL      = 3;
    localparam int CH_AW        = 0;
    localparam int CH_W         = 1;
    localparam int CH_B         = 2;
    localparam int CH_AR        = 3;
    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef struct packed {
        int          op;
        logic [31:0] addr;
        logic [7:0]  id;
        logic [3:0]  len;
        logic [31:0] data;
        int          gap;
        logic        exp_int;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic [`SCTRL_ID_W-1:0]   awid_i;
    logic [`SCTRL_ADDR_W-1:0] awaddr_i;
    logic [`SCTRL_LEN_W-1:0]  awlen_i;
    logic [1:0]               awburst_i;
    logic                     awvalid_i;
    logic                     awready_o;
    logic [`SCTRL_DATA_W-1:0] wdata_i;
    logic                     wlast_i;
    logic                     wvalid_i;
    logic                     wready_o;
    logic [`SCTRL_ID_W-1:0]   bid_o;
    logic [1:0]               bresp_o;
    logic                     bvalid_o;
    logic                     bready_i;
    logic [`SCTRL_ID_W-1:0]   arid_i;
    logic [`SCTRL_ADDR_W-1:0] araddr_i;
    logic [`SCTRL_LEN_W-1:0]  arlen_i;
    logic [1:0]               arburst_i;
    logic                     arvalid_i;
    logic                     arready_o;
    logic [`SCTRL_ID_W-1:0]   rid_o;
    logic [`SCTRL_DATA_W-1:0] rdata_o;
    logic [1:0]               rresp_o;
    logic                     rlast_o;
    logic                     rvalid_o;
    logic                     rready_i;
    logic                     sensor_ready_i;
    logic [`SCTRL_DATA_W-1:0] sensor_out_i;
    logic                     sensor_en_o;
    logic                     sctrl_int_o;

    row_t        rows[$];
    logic [31:0] ref_mem [`SCTRL_DEPTH];
    int          ref_fill;
    logic        ref_en;
    logic        ref_clr;
    logic [31:0] lfsr_q;
    int          mismatches;
    int          failures;
    logic        timed_out;

    tb_clkgen #(.PERIOD(20), .RST_CYCLES(10)) clkgen0 (
        .clk_o (clk),
        .rst_o (rst)
    );

    sctrl_top dut0 (.*);

    bind sctrl_axi_slave tb_sctrl_sva sva0 (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .bid_o     (bid_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .rlast_o   (rlast_o),
        .rid_o     (rid_o),
        .rdata_o   (rdata_o)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        int          k;
        w = '0;
        for (k = 0; k < 32; k++) begin
            w = {w[30:0], rand_bit()};
        end
        return w;
    endfunction

    // High with probability 2^-bits
    function automatic logic rand_ready(input int bits);
        logic r;
        int   k;
        r = 1'b1;
        for (k = 0; k < bits; k++) begin
            r = r & rand_bit();
        end
        return r;
    endfunction

    function automatic logic model_sensor_en();
        return ref_en & ~ref_clr & (ref_fill < `SCTRL_DEPTH);
    endfunction

    function automatic logic chan_flag(input int ch);
        case (ch)
            CH_AW:   return awready_o;
            CH_W:    return wready_o;
            CH_B:    return bvalid_o;
            default: return arready_o;
        endcase
    endfunction

    task automatic add_row(input int op, input logic [31:0] addr, input logic [7:0] id,
                           input logic [3:0] len, input logic [31:0] data, input int gap,
                           input logic exp_int);
        row_t r;
        r.op      = op;
        r.addr    = addr;
        r.id      = id;
        r.len     = len;
        r.data    = data;
        r.gap     = gap;
        r.exp_int = exp_int;
        rows.push_back(r);
    endtask

    task automatic print_counts();
        $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, dut0.slave0.sva0.fail_count);
    endtask

    task automatic report_timeout(input string what);
        failures++;
        timed_out = 1'b1;
        $display("Timeout: %s", what);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            mismatches++;
        end
    endtask

    // Called on a falling edge and returns before the rising edge that transfers
    task automatic wait_chan(input int ch, input string what);
        int n;
        n = 0;
        #2;
        while (!chan_flag(ch) && n < HS_TIMEOUT && !timed_out) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (!chan_flag(ch) && !timed_out) begin
            report_timeout(what);
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [7:0] id,
                             input logic [3:0] len, input logic [31:0] data, input logic joint);
        int         beat;
        logic [8:0] idx;
        beat = 0;
        @(negedge clk);
        awvalid_i = 1'b1;
        awid_i    = id;
        awaddr_i  = addr;
        awlen_i   = len;
        awburst_i = BURST_INCR;
        if (joint) begin
            wvalid_i = 1'b1;
            wdata_i  = data;
            wlast_i  = (len == 4'd0);
        end
        wait_chan(CH_AW, "awready never rose");
        if (joint) begin
            assert (wready_o) else begin
                $display("First write beat was not accepted together with its address");
                failures++;
            end
            beat = 1;
        end
        @(negedge clk);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        wlast_i   = 1'b0;
        // Data arrives one idle cycle after the address
        if (!joint) begin
            @(negedge clk);
        end
        while (beat <= int'(len)) begin
            wvalid_i = 1'b1;
            wdata_i  = data;
            wlast_i  = (beat == int'(len));
            wait_chan(CH_W, "wready never rose");
            @(negedge clk);
            wvalid_i = 1'b0;
            wlast_i  = 1'b0;
            beat++;
        end
        bready_i = 1'b1;
        wait_chan(CH_B, "bvalid never rose");
        check_val("bid_o", 32'(bid_o), 32'(id));
        check_val("bresp_o", 32'(bresp_o), 32'(SCTRL_RESP_OKAY));
        @(negedge clk);
        bready_i = 1'b0;
        idx = addr[10:2];
        for (beat = 0; beat <= int'(len); beat++) begin
            if (idx == `SCTRL_REG_EN) begin
                ref_en = data[0];
            end else if (idx == `SCTRL_REG_CLR) begin
                ref_clr = data[0];
            end
            idx = idx + 9'd1;
        end
        if (ref_clr) begin
            ref_fill = 0;
        end
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [7:0] id,
                            input logic [3:0] len);
        int          beat;
        int          n;
        logic        done;
        logic        held;
        logic [31:0] held_data;
        logic [5:0]  slot;
        @(negedge clk);
        arvalid_i = 1'b1;
        arid_i    = id;
        araddr_i  = addr;
        arlen_i   = len;
        arburst_i = BURST_INCR;
        wait_chan(CH_AR, "arready never rose");
        @(negedge clk);
        arvalid_i = 1'b0;
        slot = addr[7:2];
        for (beat = 0; beat <= int'(len) && !timed_out; beat++) begin
            done = 1'b0;
            held = 1'b0;
            n    = 0;
            while (!done && !timed_out) begin
                rready_i = rand_ready(1);
                #2;
                if (rvalid_o) begin
                    if (held) begin
                        check_val("rdata_o", rdata_o, held_data);
                    end
                    check_val("rdata_o", rdata_o, ref_mem[slot]);
                    check_val("rlast_o", 32'(rlast_o), 32'(beat == int'(len)));
                    check_val("rid_o", 32'(rid_o), 32'(id));
                    check_val("rresp_o", 32'(rresp_o), 32'(SCTRL_RESP_OKAY));
                    done      = rready_i;
                    held      = 1'b1;
                    held_data = rdata_o;
                end
                n++;
                if (!done && n > HS_TIMEOUT) begin
                    report_timeout("read beat never completed");
                end
                @(negedge clk);
            end
            slot = slot + 6'd1;
        end
        rready_i = 1'b0;
    endtask

    task automatic sensor_fill(input int gap);
        int   n;
        logic store;
        n = 0;
        while (ref_fill < `SCTRL_DEPTH && !timed_out) begin
            @(negedge clk);
            sensor_ready_i = rand_ready(gap);
            sensor_out_i   = rand_word();
            #2;
            check_val("sensor_en_o", 32'(sensor_en_o), 32'(model_sensor_en()));
            // Buffer not yet full
            check_val("sctrl_int_o", 32'(sctrl_int_o), 32'h0);
            store = model_sensor_en() & sensor_ready_i;
            if (store) begin
                ref_mem[ref_fill[5:0]] = sensor_out_i;
                ref_fill++;
            end
            n++;
            if (n > FILL_TIMEOUT) begin
                report_timeout("sensor fill did not complete");
            end
        end
        @(negedge clk);
        sensor_ready_i = 1'b0;
    endtask

    initial begin
        row_t row;
        int   i;
        int   n;
        lfsr_q     = 32'h3af5;
        mismatches = 0;
        failures   = 0;
        timed_out  = 1'b0;
        ref_fill   = 0;
        ref_en     = 1'b0;
        ref_clr    = 1'b0;
        awid_i     = '0;
        awaddr_i   = '0;
        awlen_i    = '0;
        awburst_i  = '0;
        awvalid_i  = 1'b0;
        wdata_i    = '0;
        wlast_i    = 1'b0;
        wvalid_i   = 1'b0;
        bready_i   = 1'b0;
        arid_i     = '0;
        araddr_i   = '0;
        arlen_i    = '0;
        arburst_i  = '0;
        arvalid_i  = 1'b0;
        rready_i   = 1'b0;
        sensor_ready_i = 1'b0;
        sensor_out_i   = '0;

        add_row(OP_WR_JOINT, 32'h0000_0100, 8'h11, 4'd0,  32'h0000_0001, 0, 1'b0);
        add_row(OP_FILL,     32'h0000_0000, 8'h00, 4'd0,  32'h0000_0000, 1, 1'b1);
        add_row(OP_RD,       32'h0000_0000, 8'h21, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_RD,       32'h0000_0040, 8'h22, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_RD,       32'h0000_0080, 8'h23, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_RD,       32'h0000_00c0, 8'h24, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_WR_SPLIT, 32'h0000_0020, 8'h31, 4'd3,  32'hdead_0000, 0, 1'b1);
        add_row(OP_RD,       32'h0000_0020, 8'h32, 4'd3,  32'h0000_0000, 0, 1'b1);
        add_row(OP_WR_SPLIT, 32'h0000_0200, 8'h41, 4'd0,  32'h0000_0001, 0, 1'b0);
        add_row(OP_WR_JOINT, 32'h0000_0200, 8'h42, 4'd0,  32'h0000_0000, 0, 1'b0);
        add_row(OP_FILL,     32'h0000_0000, 8'h00, 4'd0,  32'h0000_0000, 2, 1'b1);
        add_row(OP_RD,       32'h0000_0000, 8'h51, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_RD,       32'h0000_0040, 8'h52, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_RD,       32'h0000_0080, 8'h53, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_RD,       32'h0000_00c0, 8'h54, 4'd15, 32'h0000_0000, 0, 1'b1);
        add_row(OP_WR_JOINT, 32'h0000_00fc, 8'h61, 4'd1,  32'h0000_0001, 0, 1'b1);
        add_row(OP_RD,       32'h0000_00f8, 8'h62, 4'd3,  32'h0000_0000, 0, 1'b1);

        n = 0;
        while (!rst && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!rst) begin
            report_timeout("reset was never released");
        end
        @(negedge clk);
        #2;
        check_val("bvalid_o", 32'(bvalid_o), 32'h0);
        check_val("rvalid_o", 32'(rvalid_o), 32'h0);
        check_val("sensor_en_o", 32'(sensor_en_o), 32'h0);
        check_val("sctrl_int_o", 32'(sctrl_int_o), 32'h0);

        for (i = 0; i < rows.size() && !timed_out; i++) begin
            row = rows[i];
            case (row.op)
                OP_WR_JOINT: axi_write(row.addr, row.id, row.len, row.data, 1'b1);
                OP_WR_SPLIT: axi_write(row.addr, row.id, row.len, row.data, 1'b0);
                OP_RD:       axi_read(row.addr, row.id, row.len);
                default:     sensor_fill(row.gap);
            endcase
            @(negedge clk);
            #2;
            check_val("sctrl_int_o", 32'(sctrl_int_o), 32'(row.exp_int));
            check_val("sensor_en_o", 32'(sensor_en_o), 32'(model_sensor_en()));
        end

        print_counts();
        if (mismatches == 0 && failures == 0 && dut0.slave0.sva0.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

// File: tb_sctrl_sva.sv
`timescale 1ns/1ps
`include "sctrl_params.svh"

module tb_sctrl_sva (
    input logic                     clk,
    input logic                     rst,
    input sctrl_pkg::sctrl_state_e  state,
    input logic                     awvalid_i,
    input logic                     awready_o,
    input logic                     arvalid_i,
    input logic                     arready_o,
    input logic                     bvalid_o,
    input logic                     bready_i,
    input logic [`SCTRL_ID_W-1:0]   bid_o,
    input logic                     rvalid_o,
    input logic                     rready_i,
    input logic                     rlast_o,
    input logic [`SCTRL_ID_W-1:0]   rid_o,
    input logic [`SCTRL_DATA_W-1:0] rdata_o
);
    import sctrl_pkg::*;

    int fail_count = 0;

    a_one_resp: assert property (@(posedge clk) disable iff (!rst)
        !(rvalid_o && bvalid_o))
        else begin
            $error("rvalid and bvalid high together");
            fail_count++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid_i && !awready_o |=> awvalid_i)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid_i && !arready_o |=> arvalid_i)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end

    a_b_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o))
        else begin
            $error("bvalid or bid changed before bready");
            fail_count++;
        end

    // Read beat must hold under back-pressure
    a_r_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rlast_o)
            && $stable(rid_o))
        else begin
            $error("read beat changed before rready");
            fail_count++;
        end

    a_rlast: assert property (@(posedge clk) disable iff (!rst)
        rlast_o |-> rvalid_o && (state == RDATA))
        else begin
            $error("rlast high outside a read beat");
            fail_count++;
        end
endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // Reset let go on a falling edge
    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end
endmodule

// File: sctrl_top.sv
`timescale 1ns/1ps
`include "sctrl_params.svh"

module sctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    // Write address
    input  logic [`SCTRL_ID_W-1:0]   awid_i,
    input  logic [`SCTRL_ADDR_W-1:0] awaddr_i,
    input  logic [`SCTRL_LEN_W-1:0]  awlen_i,
    input  logic [1:0]              awburst_i,
    input  logic                    awvalid_i,
    output logic                    awready_o,
    // Write data
    input  logic [`SCTRL_DATA_W-1:0] wdata_i,
    input  logic                    wlast_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    // Write response
    output logic [`SCTRL_ID_W-1:0]   bid_o,
    output logic [1:0]              bresp_o,
    output logic                    bvalid_o,
    input  logic                    bready_i,
    // Read address
    input  logic [`SCTRL_ID_W-1:0]   arid_i,
    input  logic [`SCTRL_ADDR_W-1:0] araddr_i,
    input  logic [`SCTRL_LEN_W-1:0]  arlen_i,
    input  logic [1:0]              arburst_i,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    // Read data
    output logic [`SCTRL_ID_W-1:0]   rid_o,
    output logic [`SCTRL_DATA_W-1:0] rdata_o,
    output logic [1:0]              rresp_o,
    output logic                    rlast_o,
    output logic                    rvalid_o,
    input  logic                    rready_i,
    // Sensor
    input  logic                    sensor_ready_i,
    input  logic [`SCTRL_DATA_W-1:0] sensor_out_i,
    output logic                    sensor_en_o,
    output logic                    sctrl_int_o
);
    import sctrl_pkg::*;

    logic                    cap_en;
    logic                    cap_clear;
    logic [`SCTRL_DATA_W-1:0] rd_word;
    sctrl_idx_u              rd_slot;

    sctrl_axi_slave slave0 (
        .clk         (clk),
        .rst         (rst),
        .awid_i      (awid_i),
        .awaddr_i    (awaddr_i),
        .awlen_i     (awlen_i),
        .awburst_i   (awburst_i),
        .awvalid_i   (awvalid_i),
        .awready_o   (awready_o),
        .wdata_i     (wdata_i),
        .wlast_i     (wlast_i),
        .wvalid_i    (wvalid_i),
        .wready_o    (wready_o),
        .bid_o       (bid_o),
        .bresp_o     (bresp_o),
        .bvalid_o    (bvalid_o),
        .bready_i    (bready_i),
        .arid_i      (arid_i),
        .araddr_i    (araddr_i),
        .arlen_i     (arlen_i),
        .arburst_i   (arburst_i),
        .arvalid_i   (arvalid_i),
        .arready_o   (arready_o),
        .rid_o       (rid_o),
        .rdata_o     (rdata_o),
        .rresp_o     (rresp_o),
        .rlast_o     (rlast_o),
        .rvalid_o    (rvalid_o),
        .rready_i    (rready_i),
        .rd_word_i   (rd_word),
        .cap_en_o    (cap_en),
        .cap_clear_o (cap_clear),
        .rd_slot_o   (rd_slot)
    );

    sctrl_buffer buf0 (
        .clk            (clk),
        .rst            (rst),
        .cap_en_i       (cap_en),
        .cap_clear_i    (cap_clear),
        .rd_slot_i      (rd_slot),
        .sensor_ready_i (sensor_ready_i),
        .sensor_out_i   (sensor_out_i),
        .rd_word_o      (rd_word),
        .sensor_en_o    (sensor_en_o),
        .sctrl_int_o    (sctrl_int_o)
    );

endmodule

// File: sctrl_buffer.sv
`timescale 1ns/1ps
`include "sctrl_params.svh"

module sctrl_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cap_en_i,
    input  logic                    cap_clear_i,
    input  sctrl_pkg::sctrl_idx_u   rd_slot_i,
    input  logic                    sensor_ready_i,
    input  logic [`SCTRL_DATA_W-1:0] sensor_out_i,
    output logic [`SCTRL_DATA_W-1:0] rd_word_o,
    output logic                    sensor_en_o,
    output logic                    sctrl_int_o
);
    localparam int SLOT_W = $clog2(`SCTRL_DEPTH);

    logic [`SCTRL_DATA_W-1:0] mem [`SCTRL_DEPTH];

    // One extra bit so a full buffer is distinct from empty
    logic [SLOT_W:0] fill_q;
    logic            full;
    logic            store;

    assign full  = (fill_q == (SLOT_W+1)'(`SCTRL_DEPTH));
    assign store = sensor_en_o & sensor_ready_i;

    // Sensor runs only while enabled, not cleared and not full
    assign sensor_en_o = cap_en_i & ~cap_clear_i & ~full;

    // Level interrupt, dropped as soon as clear is set
    assign sctrl_int_o = full & ~cap_clear_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fill_q <= '0;
        end else if (cap_clear_i) begin
            fill_q <= '0;
        end else if (store) begin
            fill_q <= fill_q + (SLOT_W+1)'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            mem[fill_q[SLOT_W-1:0]] <= sensor_out_i;
        end
    end

    // Asynchronous read by slot field of the word index
    assign rd_word_o = mem[rd_slot_i.f.slot];

endmodule

// File: sctrl_axi_slave.sv
`timescale 1ns/1ps
`include "sctrl_params.svh"

module sctrl_axi_slave (
    input  logic                    clk,
    input  logic                    rst,
    // Write address
    input  logic [`SCTRL_ID_W-1:0]   awid_i,
    input  logic [`SCTRL_ADDR_W-1:0] awaddr_i,
    input  logic [`SCTRL_LEN_W-1:0]  awlen_i,
    input  logic [1:0]              awburst_i,
    input  logic                    awvalid_i,
    output logic                    awready_o,
    // Write data
    input  logic [`SCTRL_DATA_W-1:0] wdata_i,
    input  logic                    wlast_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    // Write response
    output logic [`SCTRL_ID_W-1:0]   bid_o,
    output logic [1:0]              bresp_o,
    output logic                    bvalid_o,
    input  logic                    bready_i,
    // Read address
    input  logic [`SCTRL_ID_W-1:0]   arid_i,
    input  logic [`SCTRL_ADDR_W-1:0] araddr_i,
    input  logic [`SCTRL_LEN_W-1:0]  arlen_i,
    input  logic [1:0]              arburst_i,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    // Read data
    output logic [`SCTRL_ID_W-1:0]   rid_o,
    output logic [`SCTRL_DATA_W-1:0] rdata_o,
    output logic [1:0]              rresp_o,
    output logic                    rlast_o,
    output logic                    rvalid_o,
    input  logic                    rready_i,
    // Capture buffer side
    input  logic [`SCTRL_DATA_W-1:0] rd_word_i,
    output logic                    cap_en_o,
    output logic                    cap_clear_o,
    output sctrl_pkg::sctrl_idx_u   rd_slot_o
);
    import sctrl_pkg::*;

    localparam logic [1:0] BURST_INCR = 2'b01;

    sctrl_state_e state;
    sctrl_state_e state_d;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;
    logic accept;
    logic adv;
    logic step;

    logic [`SCTRL_ID_W-1:0]  id_q;
    logic [`SCTRL_LEN_W-1:0] len_q;
    logic [1:0]             burst_q;
    logic [1:0]             burst_d;
    logic [`SCTRL_LEN_W-1:0] beat_q;
    logic [`SCTRL_LEN_W-1:0] beat_base;
    logic [`SCTRL_LEN_W-1:0] beat_d;

    sctrl_idx_u aw_idx;
    sctrl_idx_u ar_idx;
    sctrl_idx_u idx_q;
    sctrl_idx_u idx_base;
    sctrl_idx_u idx_d;

    assign aw_hs = awvalid_i & awready_o;
    assign w_hs  = wvalid_i & wready_o;
    assign b_hs  = bvalid_o & bready_i;
    assign ar_hs = arvalid_i & arready_o;
    assign r_hs  = rvalid_o & rready_i;

    // New address accepted in IDLE or as the current response finishes
    always_comb begin
        case (state)
            IDLE:    accept = 1'b1;
            BRESP:   accept = bready_i;
            RDATA:   accept = rready_i & rlast_o;
            default: accept = 1'b0;
        endcase
    end

    // Write wins a tie
    assign awready_o = accept;
    assign arready_o = accept & ~awvalid_i;
    // First W may ride along with AW in IDLE
    assign wready_o  = (state == WDATA) | ((state == IDLE) & awvalid_i);

    always_comb begin
        state_d = state;
        if (aw_hs) begin
            state_d = (w_hs & wlast_i) ? BRESP : WDATA;
        end else if (ar_hs) begin
            state_d = RDATA;
        end else begin
            case (state)
                WDATA: begin
                    if (w_hs & wlast_i) begin
                        state_d = BRESP;
                    end
                end
                BRESP: begin
                    if (b_hs) begin
                        state_d = IDLE;
                    end
                end
                RDATA: begin
                    if (r_hs & rlast_o) begin
                        state_d = IDLE;
                    end
                end
                default: state_d = state;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_d;
        end
    end

    // Index and beat tracking
    always_comb begin
        aw_idx.raw = awaddr_i[`SCTRL_IDX_W+1:2];
        ar_idx.raw = araddr_i[`SCTRL_IDX_W+1:2];
        if (aw_hs) begin
            idx_base = aw_idx;
            burst_d  = awburst_i;
        end else if (ar_hs) begin
            idx_base = ar_idx;
            burst_d  = arburst_i;
        end else begin
            idx_base = idx_q;
            burst_d  = burst_q;
        end
        // Read beat advances unless this R ends the burst under a new address
        adv  = w_hs | (r_hs & ~aw_hs & ~ar_hs);
        // Non-INCR bursts keep the index fixed
        step = (burst_d == BURST_INCR);
        idx_d.raw = adv ? idx_base.raw + `SCTRL_IDX_W'(step) : idx_base.raw;
        beat_base = (aw_hs | ar_hs) ? '0 : beat_q;
        beat_d    = adv ? beat_base + `SCTRL_LEN_W'(1) : beat_base;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx_q  <= '0;
            beat_q <= '0;
        end else begin
            idx_q  <= idx_d;
            beat_q <= beat_d;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q    <= awid_i;
            len_q   <= awlen_i;
            burst_q <= awburst_i;
        end else if (ar_hs) begin
            id_q    <= arid_i;
            len_q   <= arlen_i;
            burst_q <= arburst_i;
        end
    end

    // Control registers, other indices are dropped
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cap_en_o    <= 1'b0;
            cap_clear_o <= 1'b0;
        end else if (w_hs) begin
            if (idx_base.raw == `SCTRL_REG_EN) begin
                cap_en_o <= wdata_i[0];
            end else if (idx_base.raw == `SCTRL_REG_CLR) begin
                cap_clear_o <= wdata_i[0];
            end
        end
    end

    assign bvalid_o  = (state == BRESP);
    assign rvalid_o  = (state == RDATA);
    assign rlast_o   = (state == RDATA) & (beat_q == len_q);
    assign bid_o     = id_q;
    assign rid_o     = id_q;
    assign bresp_o   = SCTRL_RESP_OKAY;
    assign rresp_o   = SCTRL_RESP_OKAY;
    assign rdata_o   = rd_word_i;
    assign rd_slot_o = idx_q;

endmodule

// File: sctrl_pkg.sv
`include "sctrl_params.svh"

package sctrl_pkg;

    // Word index, flat for register decode or split for buffer slot select
    typedef union packed {
        logic [`SCTRL_IDX_W-1:0] raw;
        struct packed {
            logic [`SCTRL_IDX_W-$clog2(`SCTRL_DEPTH)-1:0] region;
            logic [$clog2(`SCTRL_DEPTH)-1:0]              slot;
        } f;
    } sctrl_idx_u;

    // One outstanding transaction
    typedef enum logic [1:0] {
        IDLE,
        WDATA,
        BRESP,
        RDATA
    } sctrl_state_e;

    localparam logic [1:0] SCTRL_RESP_OKAY = 2'b00;

endpackage

// File: sctrl_params.svh
`ifndef SCTRL_PARAMS_SVH
`define SCTRL_PARAMS_SVH

// Bus and sample data width
`define SCTRL_DATA_W 32

// Byte address width
`define SCTRL_ADDR_W 32

// Transaction ID width
`define SCTRL_ID_W 8

// Burst length field, 1 to 16 beats
`define SCTRL_LEN_W 4

// Word index, byte address bits 10:2
`define SCTRL_IDX_W 9

// Capture buffer depth in words
`define SCTRL_DEPTH 64

// Control register word indices
`define SCTRL_REG_EN  9'h40
`define SCTRL_REG_CLR 9'h80

`endif
